// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^=== PASS ===$$" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
source/isa_pkg.sv
source/rob_pkg.sv
source/dispatch_unit.sv
source/execute_unit.sv
source/reorder_buffer.sv
source/commit_unit.sv
source/ooo_core_top.sv
testbench/ooo_core_assertions.sv
testbench/ooo_core_tb.sv

// ==== source/commit_unit.sv ====
module commit_unit
(
    input  logic                clk_in,
    input  logic                reset_in,
    input  logic                retire_valid,
    input  rob_pkg::retire_t    retire,
    output logic                store_valid,
    output isa_pkg::addr_t      store_address,
    output isa_pkg::data_t      store_data,
    output logic [15:0]         retired_count,
    input  isa_pkg::reg_index_t read_index,
    output isa_pkg::data_t      read_data
);

    isa_pkg::data_t reg_file [isa_pkg::num_arch_reg];

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            for (int i = 0; i < isa_pkg::num_arch_reg; i++)
            begin
                reg_file[i] <= '0;
            end
            store_valid   <= 1'b0;
            retired_count <= '0;
        end
        else
        begin
            if (retire_valid && retire.writes_reg)
            begin
                reg_file[retire.dest] <= retire.value;
            end
            store_valid <= retire_valid && retire.is_store;
            if (retire_valid)
            begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        store_address <= retire.address;
        store_data    <= retire.value;
    end

    // read sees a write from the previous edge
    assign read_data = reg_file[read_index];

endmodule

// ==== source/dispatch_unit.sv ====
module dispatch_unit
#(
    parameter int num_rob_entry = 8
)
(
    input  logic                                clk_in,
    input  logic                                reset_in,
    input  logic                                flush,
    input  logic                                instr_valid,
    input  rob_pkg::instr_t                     instr,
    input  logic                                full,
    input  logic [$clog2(num_rob_entry)-1:0]    tail_tag,
    output logic                                alloc_valid,
    output rob_pkg::alloc_t                     alloc,
    output logic                                issue_valid,
    output rob_pkg::issue_t                     issue,
    output logic [15:0]                         dropped_count
);

    localparam int tag_width = $clog2(num_rob_entry);

    logic                                accept;
    logic                                writes_reg;
    logic [rob_pkg::tag_field_width-1:0] tag_ext;

    assign accept = instr_valid && !full;

    // only stores leave the register file alone
    assign writes_reg = (instr.opcode != isa_pkg::op_store);

    always_comb
    begin
        tag_ext = '0;
        tag_ext[tag_width-1:0] = tail_tag;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            alloc_valid   <= 1'b0;
            issue_valid   <= 1'b0;
            dropped_count <= '0;
        end
        else
        begin
            alloc_valid <= accept && !flush;
            issue_valid <= accept && !flush;
            if (instr_valid && full)
            begin
                dropped_count <= dropped_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            alloc.tag        <= tag_ext;
            alloc.opcode     <= instr.opcode;
            alloc.dest       <= instr.dest;
            alloc.address    <= instr.address;
            alloc.writes_reg <= writes_reg;
            issue.tag        <= tag_ext;
            issue.opcode     <= instr.opcode;
            issue.operand_a  <= instr.operand_a;
            issue.operand_b  <= instr.operand_b;
        end
    end

endmodule

// ==== source/execute_unit.sv ====
module execute_unit
#(
    parameter int num_rob_entry = 8
)
(
    input  logic            clk_in,
    input  logic            reset_in,
    input  logic            flush,
    input  logic            issue_valid,
    input  rob_pkg::issue_t issue,
    output logic            fast_valid,
    output logic            slow_valid,
    output rob_pkg::wb_t    fast_wb,
    output rob_pkg::wb_t    slow_wb
);

    rob_pkg::exec_class_t issue_class;
    isa_pkg::data_t       fast_result;
    logic                 fast_go;
    logic                 slow_go;

    // multiplier stages
    logic                                s1_valid;
    logic [rob_pkg::tag_field_width-1:0] s1_tag;
    isa_pkg::data_t                      s1_a;
    isa_pkg::data_t                      s1_b;
    logic                                s2_valid;
    logic [rob_pkg::tag_field_width-1:0] s2_tag;
    isa_pkg::data_t                      s2_product;

    always_comb
    begin
        issue_class = (issue.opcode == isa_pkg::op_mul) ? rob_pkg::class_slow
                                                        : rob_pkg::class_fast;
        case (issue.opcode)
            isa_pkg::op_add:   fast_result = issue.operand_a + issue.operand_b;
            isa_pkg::op_sub:   fast_result = issue.operand_a - issue.operand_b;
            isa_pkg::op_xor:   fast_result = issue.operand_a ^ issue.operand_b;
            // store value is its data operand
            isa_pkg::op_store: fast_result = issue.operand_a;
            default:           fast_result = '0;
        endcase
    end

    assign fast_go = issue_valid && (issue_class == rob_pkg::class_fast);
    assign slow_go = issue_valid && (issue_class == rob_pkg::class_slow);

    always_ff @(posedge clk_in)
    begin
        if (reset_in || flush)
        begin
            fast_valid <= 1'b0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            slow_valid <= 1'b0;
        end
        else
        begin
            fast_valid <= fast_go;
            s1_valid   <= slow_go;
            s2_valid   <= s1_valid;
            slow_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk_in)
    begin
        fast_wb.tag   <= issue.tag;
        fast_wb.value <= fast_result;
        s1_tag        <= issue.tag;
        s1_a          <= issue.operand_a;
        s1_b          <= issue.operand_b;
        s2_tag        <= s1_tag;
        // low word of the product
        s2_product    <= s1_a * s1_b;
        slow_wb.tag   <= s2_tag;
        slow_wb.value <= s2_product;
    end

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    localparam int num_arch_reg = 32;

    // instruction set seen by the core
    typedef enum logic [2:0]
    {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_xor   = 3'd2,
        op_mul   = 3'd3,
        op_store = 3'd4
    } opcode_t;

    typedef logic [$clog2(num_arch_reg)-1:0] reg_index_t;

    typedef logic [31:0] data_t;

    // store target
    typedef logic [15:0] addr_t;

endpackage

// ==== source/ooo_core_top.sv ====
module ooo_core_top
#(
    parameter int num_rob_entry = 8
)
(
    input  logic                clk_in,
    input  logic                reset_in,
    input  logic                flush,
    input  logic                instr_valid,
    input  rob_pkg::instr_t     instr,
    output logic                full,
    output logic [15:0]         dropped_count,
    output logic                retire_valid,
    output rob_pkg::retire_t    retire,
    output logic                store_valid,
    output isa_pkg::addr_t      store_address,
    output isa_pkg::data_t      store_data,
    output logic [15:0]         retired_count,
    input  isa_pkg::reg_index_t read_index,
    output isa_pkg::data_t      read_data
);

    localparam int tag_width = $clog2(num_rob_entry);

    logic [tag_width-1:0] tail_tag;
    logic                 alloc_valid;
    rob_pkg::alloc_t      alloc;
    logic                 issue_valid;
    rob_pkg::issue_t      issue;
    logic                 fast_valid;
    logic                 slow_valid;
    rob_pkg::wb_t         fast_wb;
    rob_pkg::wb_t         slow_wb;

    dispatch_unit #(.num_rob_entry(num_rob_entry)) dispatch_inst
    (
        .clk_in(clk_in), .reset_in(reset_in), .flush(flush),
        .instr_valid(instr_valid), .instr(instr), .full(full), .tail_tag(tail_tag),
        .alloc_valid(alloc_valid), .alloc(alloc),
        .issue_valid(issue_valid), .issue(issue), .dropped_count(dropped_count)
    );

    execute_unit #(.num_rob_entry(num_rob_entry)) execute_inst
    (
        .clk_in(clk_in), .reset_in(reset_in), .flush(flush),
        .issue_valid(issue_valid), .issue(issue),
        .fast_valid(fast_valid), .slow_valid(slow_valid),
        .fast_wb(fast_wb), .slow_wb(slow_wb)
    );

    reorder_buffer #(.num_rob_entry(num_rob_entry)) rob_inst
    (
        .clk_in(clk_in), .reset_in(reset_in), .flush(flush),
        .alloc_valid(alloc_valid), .alloc(alloc),
        .fast_valid(fast_valid), .slow_valid(slow_valid),
        .fast_wb(fast_wb), .slow_wb(slow_wb),
        .full(full), .tail_tag(tail_tag),
        .retire_valid(retire_valid), .retire(retire)
    );

    // register file is not flushed
    commit_unit commit_inst
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .retire_valid(retire_valid), .retire(retire),
        .store_valid(store_valid), .store_address(store_address), .store_data(store_data),
        .retired_count(retired_count), .read_index(read_index), .read_data(read_data)
    );

endmodule

// ==== source/reorder_buffer.sv ====
module reorder_buffer
#(
    parameter int num_rob_entry = 8
)
(
    input  logic                                clk_in,
    input  logic                                reset_in,
    input  logic                                flush,
    input  logic                                alloc_valid,
    input  rob_pkg::alloc_t                     alloc,
    input  logic                                fast_valid,
    input  logic                                slow_valid,
    input  rob_pkg::wb_t                        fast_wb,
    input  rob_pkg::wb_t                        slow_wb,
    output logic                                full,
    output logic [$clog2(num_rob_entry)-1:0]    tail_tag,
    output logic                                retire_valid,
    output rob_pkg::retire_t                    retire
);

    localparam int tag_width   = $clog2(num_rob_entry);
    localparam int count_width = $clog2(num_rob_entry + 1);

    logic [num_rob_entry-1:0] busy;
    logic [num_rob_entry-1:0] ready;
    logic [num_rob_entry-1:0] writes_reg_bits;
    isa_pkg::opcode_t         opcode_table  [num_rob_entry];
    isa_pkg::reg_index_t      dest_table    [num_rob_entry];
    isa_pkg::addr_t           address_table [num_rob_entry];
    isa_pkg::data_t           value_table   [num_rob_entry];

    logic [tag_width-1:0]   head_ptr;
    logic [tag_width-1:0]   tail_ptr;
    logic [count_width-1:0] count;
    logic [count_width-1:0] occupancy;

    logic [tag_width-1:0] fast_tag;
    logic [tag_width-1:0] slow_tag;
    logic                 head_hit_fast;
    logic                 head_hit_slow;
    logic                 retire_fire;
    isa_pkg::data_t       head_value;

    function automatic logic [tag_width-1:0] next_ptr(input logic [tag_width-1:0] ptr);
        if (ptr == tag_width'(num_rob_entry - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a pending allocation already owns the tail slot
    assign occupancy = count + count_width'(alloc_valid);
    assign full      = (occupancy == count_width'(num_rob_entry));
    assign tail_tag  = alloc_valid ? next_ptr(tail_ptr) : tail_ptr;

    assign fast_tag = fast_wb.tag[tag_width-1:0];
    assign slow_tag = slow_wb.tag[tag_width-1:0];

    // head may complete in the same cycle it retires
    assign head_hit_fast = fast_valid && (fast_tag == head_ptr);
    assign head_hit_slow = slow_valid && (slow_tag == head_ptr);
    assign retire_fire   = busy[head_ptr] && (ready[head_ptr] || head_hit_fast || head_hit_slow);
    assign head_value    = head_hit_fast ? fast_wb.value :
                           head_hit_slow ? slow_wb.value : value_table[head_ptr];

    always_ff @(posedge clk_in)
    begin
        if (reset_in || flush)
        begin
            busy         <= '0;
            ready        <= '0;
            head_ptr     <= '0;
            tail_ptr     <= '0;
            count        <= '0;
            retire_valid <= 1'b0;
        end
        else
        begin
            if (alloc_valid)
            begin
                busy[tail_ptr]  <= 1'b1;
                ready[tail_ptr] <= 1'b0;
                tail_ptr        <= next_ptr(tail_ptr);
            end
            if (fast_valid)
            begin
                ready[fast_tag] <= 1'b1;
            end
            if (slow_valid)
            begin
                ready[slow_tag] <= 1'b1;
            end
            if (retire_fire)
            begin
                busy[head_ptr] <= 1'b0;
                head_ptr       <= next_ptr(head_ptr);
            end
            case ({alloc_valid, retire_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            retire_valid <= retire_fire;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (alloc_valid)
        begin
            opcode_table[tail_ptr]    <= alloc.opcode;
            dest_table[tail_ptr]      <= alloc.dest;
            address_table[tail_ptr]   <= alloc.address;
            writes_reg_bits[tail_ptr] <= alloc.writes_reg;
        end
        if (fast_valid)
        begin
            value_table[fast_tag] <= fast_wb.value;
        end
        if (slow_valid)
        begin
            value_table[slow_tag] <= slow_wb.value;
        end
        if (retire_fire)
        begin
            retire.dest       <= dest_table[head_ptr];
            retire.value      <= head_value;
            retire.address    <= address_table[head_ptr];
            retire.writes_reg <= writes_reg_bits[head_ptr];
            retire.is_store   <= (opcode_table[head_ptr] == isa_pkg::op_store);
        end
    end

endmodule

// ==== source/rob_pkg.sv ====
package rob_pkg;

    // room for the largest tag; modules use only the low clog2 bits
    localparam int tag_field_width = 4;

    typedef enum logic
    {
        class_fast = 1'b0,
        class_slow = 1'b1
    } exec_class_t;

    typedef struct packed
    {
        isa_pkg::opcode_t    opcode;
        isa_pkg::reg_index_t dest;
        isa_pkg::data_t      operand_a;
        isa_pkg::data_t      operand_b;
        isa_pkg::addr_t      address;
    } instr_t;

    // dispatch to execute
    typedef struct packed
    {
        logic [tag_field_width-1:0] tag;
        isa_pkg::opcode_t           opcode;
        isa_pkg::data_t             operand_a;
        isa_pkg::data_t             operand_b;
    } issue_t;

    // dispatch to reorder buffer
    typedef struct packed
    {
        logic [tag_field_width-1:0] tag;
        isa_pkg::opcode_t           opcode;
        isa_pkg::reg_index_t        dest;
        isa_pkg::addr_t             address;
        logic                       writes_reg;
    } alloc_t;

    typedef struct packed
    {
        logic [tag_field_width-1:0] tag;
        isa_pkg::data_t             value;
    } wb_t;

    typedef struct packed
    {
        isa_pkg::reg_index_t dest;
        isa_pkg::data_t      value;
        isa_pkg::addr_t      address;
        logic                writes_reg;
        logic                is_store;
    } retire_t;

endpackage

// ==== testbench/ooo_core_assertions.sv ====
module ooo_core_assertions
(
    input logic             clk_in,
    input logic             reset_in,
    input logic             flush,
    input logic             alloc_valid,
    input logic             full,
    input logic             retire_valid,
    input rob_pkg::retire_t retire,
    input logic             store_valid,
    input logic [15:0]      retired_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] dispatched_total;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            dispatched_total <= '0;
        end
        else if (flush)
        begin
            // flushed entries never retire, a visible retire still counts
            dispatched_total <= retired_count + 16'(retire_valid);
        end
        else if (alloc_valid)
        begin
            dispatched_total <= dispatched_total + 16'd1;
        end
    end

    retire_quiet_in_reset: assert property (@(posedge clk_in) reset_in |=> !retire_valid)
        else $error("retire_valid active during reset");

    store_after_store_retire: assert property (@(posedge clk_in) disable iff (reset_in)
        store_valid |-> $past(retire_valid && retire.is_store))
        else $error("store_valid without a retired store");

    // nothing outstanding means an empty buffer
    no_full_when_idle: assert property (@(posedge clk_in) disable iff (reset_in)
        (retired_count == dispatched_total) |-> !full)
        else $error("full while every dispatched instruction has retired");

endmodule

bind ooo_core_top ooo_core_assertions assertions_inst
(
    .clk_in(clk_in),
    .reset_in(reset_in),
    .flush(flush),
    .alloc_valid(alloc_valid),
    .full(full),
    .retire_valid(retire_valid),
    .retire(retire),
    .store_valid(store_valid),
    .retired_count(retired_count)
);

// ==== testbench/ooo_core_tb.sv ====
module ooo_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // small buffer so a stream of muls fills it
    localparam int rob_entries = 4;
    localparam int wait_limit  = 100;

    logic                clk_in;
    logic                reset_in;
    logic                flush;
    logic                instr_valid;
    rob_pkg::instr_t     instr;
    logic                full;
    logic [15:0]         dropped_count;
    logic                retire_valid;
    rob_pkg::retire_t    retire;
    logic                store_valid;
    isa_pkg::addr_t      store_address;
    isa_pkg::data_t      store_data;
    logic [15:0]         retired_count;
    isa_pkg::reg_index_t read_index;
    isa_pkg::data_t      read_data;

    rob_pkg::retire_t expected_q [$];
    isa_pkg::data_t   model_regs [isa_pkg::num_arch_reg];
    logic             store_pending;
    isa_pkg::addr_t   store_address_exp;
    isa_pkg::data_t   store_data_exp;
    int               accepted_total;
    int               flushed_total;
    int               dropped_total;
    int               stores_seen;
    logic [31:0]      rng_state;
    string            test_name;

    ooo_core_top #(.num_rob_entry(rob_entries)) uut
    (
        .clk_in(clk_in), .reset_in(reset_in), .flush(flush),
        .instr_valid(instr_valid), .instr(instr), .full(full),
        .dropped_count(dropped_count), .retire_valid(retire_valid), .retire(retire),
        .store_valid(store_valid), .store_address(store_address), .store_data(store_data),
        .retired_count(retired_count), .read_index(read_index), .read_data(read_data)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic isa_pkg::data_t reference_value(input isa_pkg::opcode_t op,
                                                       input isa_pkg::data_t a,
                                                       input isa_pkg::data_t b);
        logic [63:0] product;
        product = {32'b0, a} * {32'b0, b};
        case (op)
            isa_pkg::op_add:   return a + b;
            isa_pkg::op_sub:   return a - b;
            isa_pkg::op_xor:   return a ^ b;
            isa_pkg::op_mul:   return product[31:0];
            isa_pkg::op_store: return a;
            default:           return '0;
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("%s (%s)", what, test_name);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s %s expected %0h actual %0h", test_name, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_instr(input isa_pkg::opcode_t op, input isa_pkg::reg_index_t dest,
                              input isa_pkg::data_t a, input isa_pkg::data_t b,
                              input isa_pkg::addr_t address);
        rob_pkg::retire_t rec;
        @(posedge clk_in);
        #2;
        instr_valid     = 1'b1;
        instr.opcode    = op;
        instr.dest      = dest;
        instr.operand_a = a;
        instr.operand_b = b;
        instr.address   = address;
        @(negedge clk_in);
        // full here is what the next edge sees
        if (full)
        begin
            dropped_total++;
        end
        else
        begin
            rec.dest       = dest;
            rec.value      = reference_value(op, a, b);
            rec.address    = address;
            rec.writes_reg = (op != isa_pkg::op_store);
            rec.is_store   = (op == isa_pkg::op_store);
            expected_q.push_back(rec);
            accepted_total++;
        end
    endtask

    task automatic send_random();
        isa_pkg::opcode_t op;
        op = isa_pkg::opcode_t'(next_random() % 5);
        send_instr(op, isa_pkg::reg_index_t'(next_random()), next_random(), next_random(),
                   isa_pkg::addr_t'(next_random()));
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk_in);
            #2;
            instr_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        go_idle(1);
        while (expected_q.size() != 0)
        begin
            if (waited >= wait_limit)
            begin
                abort_run("timeout waiting for outstanding instructions to retire");
            end
            @(posedge clk_in);
            waited++;
        end
        // last register write and store strobe land here
        repeat (2) @(posedge clk_in);
        #2;
        check("retired count", accepted_total - flushed_total, retired_count);
        check("dropped count", dropped_total, dropped_count);
    endtask

    task automatic check_registers();
        for (int i = 0; i < isa_pkg::num_arch_reg; i++)
        begin
            read_index = isa_pkg::reg_index_t'(i);
            #1;
            check($sformatf("register r%0d", i), model_regs[i], read_data);
        end
    endtask

    task automatic flush_pipeline();
        @(posedge clk_in);
        #2;
        instr_valid = 1'b0;
        flush       = 1'b1;
        @(posedge clk_in);
        flushed_total += expected_q.size();
        expected_q.delete();
        #2;
        flush = 1'b0;
    endtask

    always @(negedge clk_in)
    begin : compare_outputs
        rob_pkg::retire_t head;
        if (!reset_in)
        begin
            if (store_valid)
            begin
                if (!store_pending)
                begin
                    abort_run("store strobe without a retired store");
                end
                check("store address", store_address_exp, store_address);
                check("store data", store_data_exp, store_data);
                stores_seen++;
            end
            else if (store_pending)
            begin
                abort_run("no store strobe after a retired store");
            end
            store_pending = 1'b0;
            if (retire_valid)
            begin
                if (expected_q.size() == 0)
                begin
                    abort_run("retirement with no instruction outstanding");
                end
                head = expected_q.pop_front();
                check("retire dest", head.dest, retire.dest);
                check("retire value", head.value, retire.value);
                check("retire address", head.address, retire.address);
                check("retire writes_reg", head.writes_reg, retire.writes_reg);
                check("retire is_store", head.is_store, retire.is_store);
                if (head.writes_reg)
                begin
                    model_regs[head.dest] = head.value;
                end
                if (head.is_store)
                begin
                    store_pending     = 1'b1;
                    store_address_exp = head.address;
                    store_data_exp    = head.value;
                end
            end
        end
    end

    initial
    begin
        isa_pkg::opcode_t op;
        isa_pkg::data_t   a;
        isa_pkg::data_t   b;
        int               mark;
        int               base;
        int               fill_depth;
        reset_in       = 1'b1;
        flush          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        read_index     = '0;
        store_pending  = 1'b0;
        accepted_total = 0;
        flushed_total  = 0;
        dropped_total  = 0;
        stores_seen    = 0;
        rng_state      = 32'h1cde;
        test_name      = "reset";
        for (int i = 0; i < isa_pkg::num_arch_reg; i++)
        begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk_in);
        #2;
        reset_in = 1'b0;

        test_name = "single";
        for (int k = 0; k < 5; k++)
        begin
            op = isa_pkg::opcode_t'(k);
            a  = next_random();
            b  = next_random();
            send_instr(op, isa_pkg::reg_index_t'(k + 1), a, b, isa_pkg::addr_t'(k * 273));
            wait_drain();
            if (op != isa_pkg::op_store)
            begin
                read_index = isa_pkg::reg_index_t'(k + 1);
                #1;
                check("read back", reference_value(op, a, b), read_data);
            end
            check_registers();
        end

        // mul at the head, adds finish first
        test_name = "out of order";
        send_instr(isa_pkg::op_mul, 5'd10, next_random(), next_random(), 16'h0);
        for (int k = 0; k < 4; k++)
        begin
            send_instr(isa_pkg::op_add, isa_pkg::reg_index_t'(11 + k), next_random(),
                       next_random(), 16'h0);
        end
        wait_drain();
        check_registers();

        test_name = "store";
        mark = stores_seen;
        send_instr(isa_pkg::op_store, 5'd10, 32'hcafe_0001, 32'h5, 16'h04a0);
        send_instr(isa_pkg::op_store, 5'd11, 32'h1234_5678, 32'h9, 16'hbeef);
        wait_drain();
        check("store strobes", mark + 2, stores_seen);
        check_registers();

        test_name = "full and drop";
        mark       = dropped_total;
        base       = accepted_total;
        fill_depth = -1;
        repeat (16)
        begin
            send_instr(isa_pkg::op_mul, isa_pkg::reg_index_t'(next_random()), next_random(),
                       next_random(), 16'h0);
            // empty buffer holds every entry before the first mul retires
            if (fill_depth < 0 && dropped_total != mark)
            begin
                fill_depth = accepted_total - base;
            end
        end
        if (dropped_total == mark)
        begin
            abort_run("buffer never filled under a stream of muls");
        end
        check("accepted before full", rob_entries, fill_depth);
        wait_drain();
        check_registers();

        test_name = "flush";
        send_instr(isa_pkg::op_mul, 5'd20, next_random(), next_random(), 16'h0);
        send_instr(isa_pkg::op_add, 5'd21, next_random(), next_random(), 16'h0);
        send_instr(isa_pkg::op_mul, 5'd22, next_random(), next_random(), 16'h0);
        flush_pipeline();
        // any retirement now has an empty queue to match
        go_idle(8);
        check_registers();
        send_instr(isa_pkg::op_add, 5'd20, next_random(), next_random(), 16'h0);
        send_instr(isa_pkg::op_mul, 5'd22, next_random(), next_random(), 16'h0);
        wait_drain();
        check_registers();

        test_name = "random";
        repeat (300)
        begin
            send_random();
            if ((next_random() & 32'h7) == 0)
            begin
                go_idle(1 + int'(next_random() % 3));
            end
        end
        wait_drain();
        check_registers();

        $display("=== PASS ===");
        $finish;
    end

endmodule
